// File: verilog.f
verilog/ecc_pkg.sv
verilog/ecc_48_cal.sv
verilog/ecc_word_ram.sv
verilog/ecc_req_fifo.sv
verilog/ecc_mem_ctrl.sv
verilog/ecc_err_log.sv
verilog/ecc_mem_top.sv
tests/ecc_mem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the ECC word store testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module ecc_mem_tb -o ecc_mem_sim \
    || { echo "Build failed"; exit 1; }

sim_out="$(./obj_dir/ecc_mem_sim)"
echo "$sim_out"

echo "$sim_out" | grep -q "All checks passed" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: tests/ecc_mem_tb.sv
module ecc_mem_tb;

    localparam int CREDIT_TIMEOUT = 50;
    localparam int DRAIN_TIMEOUT  = 200;
    localparam int BURST_LEN      = 40;

    // One table row; exp is only used by reads.
    typedef struct packed {
        ecc_pkg::mem_req_t  req;
        ecc_pkg::mem_resp_t exp;
    } row_t;

    logic               clk;
    logic               rst_n;
    logic               req_valid;
    ecc_pkg::mem_req_t  req;
    logic               credit_return;
    logic               resp_valid;
    ecc_pkg::mem_resp_t resp;
    ecc_pkg::cnt_t      sbit_cnt;
    ecc_pkg::cnt_t      dbit_cnt;
    ecc_pkg::addr_t     last_dbit_addr;

    row_t               table_q[$];
    ecc_pkg::mem_resp_t exp_q[$];
    ecc_pkg::data_t     model_data [ecc_pkg::MEM_DEPTH];  // As stored after injection.
    ecc_pkg::data_t     model_mask [ecc_pkg::MEM_DEPTH];
    logic               model_written [ecc_pkg::MEM_DEPTH];
    ecc_pkg::cnt_t      exp_sbit_cnt;
    ecc_pkg::cnt_t      exp_dbit_cnt;
    ecc_pkg::addr_t     exp_last_dbit;
    int                 seed = 32'hb8b1;
    int                 sent;
    int                 returned;
    int                 data_errs;
    int                 flag_errs;
    int                 cnt_errs;
    int                 addr_errs;
    int                 other_errs;
    logic               timed_out;

    ecc_mem_top uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req            (req),
        .credit_return  (credit_return),
        .resp_valid     (resp_valid),
        .resp           (resp),
        .sbit_cnt       (sbit_cnt),
        .dbit_cnt       (dbit_cnt),
        .last_dbit_addr (last_dbit_addr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_data(input string name, input ecc_pkg::data_t got,
                              input ecc_pkg::data_t exp);
        if (got !== exp) begin
            data_errs++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errs++;
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_cnt(input string name, input ecc_pkg::cnt_t got,
                             input ecc_pkg::cnt_t exp);
        if (got !== exp) begin
            cnt_errs++;
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input ecc_pkg::addr_t got,
                              input ecc_pkg::addr_t exp);
        if (got !== exp) begin
            addr_errs++;
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        other_errs++;
        $display("Failure at %0t: %s", $time, msg);
    endtask

    function automatic int total_errors();
        return data_errs + flag_errs + cnt_errs + addr_errs + other_errs;
    endfunction

    task automatic print_summary();
        $display("Summary: %0d data, %0d flag, %0d count, %0d address, %0d other errors",
                 data_errs, flag_errs, cnt_errs, addr_errs, other_errs);
    endtask

    // Checks every output at the next falling edge.
    task automatic next_cycle();
        ecc_pkg::mem_resp_t want;
        @(negedge clk);
        // Counters only reflect responses seen in earlier cycles.
        check_cnt("sbit_cnt", sbit_cnt, exp_sbit_cnt);
        check_cnt("dbit_cnt", dbit_cnt, exp_dbit_cnt);
        check_addr("last_dbit_addr", last_dbit_addr, exp_last_dbit);
        if (credit_return === 1'b1) begin
            returned++;
            if (returned > sent) begin
                report_failure("credit returned with no request outstanding");
            end
        end
        if (resp_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                report_failure("response arrived with no read outstanding");
            end else begin
                want = exp_q.pop_front();
                check_addr("resp.addr", resp.addr, want.addr);
                check_data("resp.data", resp.data, want.data);
                check_flag("resp.sbit_err", resp.sbit_err, want.sbit_err);
                check_flag("resp.dbit_err", resp.dbit_err, want.dbit_err);
                if (want.sbit_err) exp_sbit_cnt++;
                if (want.dbit_err) begin
                    exp_dbit_cnt++;
                    exp_last_dbit = want.addr;
                end
            end
        end
    endtask

    task automatic add_write(input ecc_pkg::addr_t addr, input ecc_pkg::data_t data,
                             input ecc_pkg::data_t mask);
        row_t row;
        row              = '0;
        row.req.op       = ecc_pkg::OP_WRITE;
        row.req.addr     = addr;
        row.req.data     = data;
        row.req.inj_mask = mask;
        model_data[addr]    = data ^ mask;
        model_mask[addr]    = mask;
        model_written[addr] = 1'b1;
        table_q.push_back(row);
    endtask

    task automatic add_read(input ecc_pkg::addr_t addr, input logic bypass,
                            input ecc_pkg::data_t exp_data, input logic exp_sbit,
                            input logic exp_dbit);
        row_t row;
        row              = '0;
        row.req.op       = ecc_pkg::OP_READ;
        row.req.addr     = addr;
        row.req.bypass   = bypass;
        row.exp.addr     = addr;
        row.exp.data     = exp_data;
        row.exp.sbit_err = exp_sbit;
        row.exp.dbit_err = exp_dbit;
        table_q.push_back(row);
    endtask

    // A single flip is corrected and a double one is flagged as stored.
    task automatic add_model_read(input ecc_pkg::addr_t addr, input logic bypass);
        ecc_pkg::data_t stored;
        int             flips;
        stored = model_data[addr];
        flips  = $countones(model_mask[addr]);
        if (bypass) begin
            add_read(addr, 1'b1, stored, 1'b0, 1'b0);
        end else if (flips == 1) begin
            add_read(addr, 1'b0, stored ^ model_mask[addr], 1'b1, 1'b0);
        end else begin
            add_read(addr, 1'b0, stored, 1'b0, flips == 2);
        end
    endtask

    function automatic ecc_pkg::data_t random_data();
        logic [63:0] wide;
        wide = {$random(seed), $random(seed)};
        return wide[ecc_pkg::DATA_W-1:0];
    endfunction

    // Zero, one or two distinct flipped bits.
    function automatic ecc_pkg::data_t random_mask();
        int             flips;
        int             pos_a;
        int             pos_b;
        ecc_pkg::data_t m;
        flips = $unsigned($random(seed)) % 3;
        pos_a = $unsigned($random(seed)) % ecc_pkg::DATA_W;
        pos_b = (pos_a + 1 + $unsigned($random(seed)) % (ecc_pkg::DATA_W - 1)) % ecc_pkg::DATA_W;
        m = '0;
        if (flips >= 1) m[pos_a] = 1'b1;
        if (flips == 2) m[pos_b] = 1'b1;
        return m;
    endfunction

    task automatic build_directed();
        add_write(6'd1, 48'h1234_5678_9abc, 48'h0);
        add_read(6'd1, 1'b0, 48'h1234_5678_9abc, 1'b0, 1'b0);
        add_write(6'd2, 48'hdead_beef_0042, 48'h0000_0000_0020);
        add_read(6'd2, 1'b0, 48'hdead_beef_0042, 1'b1, 1'b0);
        add_write(6'd3, 48'h0f0f_f0f0_5a5a, 48'h8000_0000_0000);
        add_read(6'd3, 1'b0, 48'h0f0f_f0f0_5a5a, 1'b1, 1'b0);
        add_write(6'd4, 48'hcafe_0000_1357, 48'h0000_0000_2001);
        add_read(6'd4, 1'b0, 48'hcafe_0000_3356, 1'b0, 1'b1);
        add_write(6'd5, 48'h7777_8888_9999, 48'h0100_0010_0000);
        add_read(6'd5, 1'b0, 48'h7677_8898_9999, 1'b0, 1'b1);
        add_read(6'd4, 1'b1, 48'hcafe_0000_3356, 1'b0, 1'b0);  // Raw and still corrupted.
        add_read(6'd2, 1'b1, 48'hdead_beef_0062, 1'b0, 1'b0);
        add_read(6'd1, 1'b1, 48'h1234_5678_9abc, 1'b0, 1'b0);
        add_read(6'd2, 1'b0, 48'hdead_beef_0042, 1'b1, 1'b0);
    endtask

    task automatic build_burst();
        logic [31:0]    r;
        ecc_pkg::addr_t addr;
        for (int i = 0; i < BURST_LEN; i++) begin
            r    = $random(seed);
            addr = ecc_pkg::addr_t'(r[3:0]);  // Small address range so reads hit earlier writes.
            if (r[8] || !model_written[addr]) begin
                add_write(addr, random_data(), random_mask());
            end else begin
                add_model_read(addr, r[13:12] == 2'b00);
            end
        end
    endtask

    task automatic send_row(input row_t row);
        int waited;
        waited = 0;
        while (!timed_out && (sent - returned >= ecc_pkg::REQ_DEPTH)) begin
            req_valid = 1'b0;
            next_cycle();
            waited++;
            if (waited > CREDIT_TIMEOUT) begin
                report_failure("timeout waiting for a request credit");
                timed_out = 1'b1;
            end
        end
        if (!timed_out) begin
            req_valid = 1'b1;
            req       = row.req;
            sent++;
            if (row.req.op == ecc_pkg::OP_READ) exp_q.push_back(row.exp);
            next_cycle();
        end
    endtask

    initial begin
        int waited;
        rst_n         = 1'b0;
        req_valid     = 1'b0;
        req           = '0;
        sent          = 0;
        returned      = 0;
        timed_out     = 1'b0;
        exp_sbit_cnt  = '0;
        exp_dbit_cnt  = '0;
        exp_last_dbit = '0;
        foreach (model_written[i]) model_written[i] = 1'b0;
        build_directed();
        build_burst();

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_flag("resp_valid", resp_valid, 1'b0);
        check_flag("credit_return", credit_return, 1'b0);

        foreach (table_q[i]) send_row(table_q[i]);
        req_valid = 1'b0;
        req       = '0;

        waited = 0;
        while (!timed_out && (exp_q.size() != 0 || returned != sent)) begin
            next_cycle();
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                report_failure("timeout waiting for responses and credits");
                timed_out = 1'b1;
            end
        end
        if (!timed_out) begin
            repeat (4) next_cycle();  // Stray pulses and the last counter update.
            if (returned != sent) begin
                report_failure("credit returns do not match the requests sent");
            end
        end

        print_summary();
        if (total_errors() == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: verilog/ecc_mem_top.sv
module ecc_mem_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_valid,
    input  ecc_pkg::mem_req_t  req,
    output logic               credit_return,
    output logic               resp_valid,
    output ecc_pkg::mem_resp_t resp,
    output ecc_pkg::cnt_t      sbit_cnt,
    output ecc_pkg::cnt_t      dbit_cnt,
    output ecc_pkg::addr_t     last_dbit_addr
);

    logic               issue_valid;
    ecc_pkg::mem_req_t  issue_req;
    logic               ram_we;
    ecc_pkg::addr_t     ram_addr;
    ecc_pkg::codeword_t ram_wdata;
    ecc_pkg::codeword_t ram_rdata;

    ecc_req_fifo req_fifo_u (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req           (req),
        .issue_valid   (issue_valid),
        .issue_req     (issue_req),
        .credit_return (credit_return)
    );

    ecc_mem_ctrl mem_ctrl_u (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_req   (issue_req),
        .ram_we      (ram_we),
        .ram_addr    (ram_addr),
        .ram_wdata   (ram_wdata),
        .ram_rdata   (ram_rdata),
        .resp_valid  (resp_valid),
        .resp        (resp)
    );

    ecc_word_ram word_ram_u (
        .clk   (clk),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    ecc_err_log err_log_u (
        .clk            (clk),
        .rst_n          (rst_n),
        .resp_valid     (resp_valid),
        .resp           (resp),
        .sbit_cnt       (sbit_cnt),
        .dbit_cnt       (dbit_cnt),
        .last_dbit_addr (last_dbit_addr)
    );

endmodule

// File: verilog/ecc_err_log.sv
module ecc_err_log (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               resp_valid,
    input  ecc_pkg::mem_resp_t resp,
    output ecc_pkg::cnt_t      sbit_cnt,
    output ecc_pkg::cnt_t      dbit_cnt,
    output ecc_pkg::addr_t     last_dbit_addr
);

    // Holds at all ones.
    function automatic ecc_pkg::cnt_t sat_inc(input ecc_pkg::cnt_t cnt);
        return (cnt == '1) ? cnt : cnt + ecc_pkg::cnt_t'(1);
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sbit_cnt       <= '0;
            dbit_cnt       <= '0;
            last_dbit_addr <= '0;
        end else if (resp_valid) begin
            if (resp.sbit_err) begin
                sbit_cnt <= sat_inc(sbit_cnt);
            end
            if (resp.dbit_err) begin
                dbit_cnt       <= sat_inc(dbit_cnt);
                last_dbit_addr <= resp.addr;  // Most recent one wins.
            end
        end
    end

endmodule

// File: verilog/ecc_mem_ctrl.sv
module ecc_mem_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               issue_valid,
    input  ecc_pkg::mem_req_t  issue_req,
    output logic               ram_we,
    output ecc_pkg::addr_t     ram_addr,
    output ecc_pkg::codeword_t ram_wdata,
    input  ecc_pkg::codeword_t ram_rdata,
    output logic               resp_valid,
    output ecc_pkg::mem_resp_t resp
);

    logic             issue_wr;
    logic             issue_rd;
    ecc_pkg::parity_t enc_parity;
    logic             rd_valid;    // Read address is at the RAM.
    logic             rd_bypass;
    logic             chk_valid;   // Codeword is on ram_rdata.
    logic             chk_bypass;
    ecc_pkg::addr_t   chk_addr;
    ecc_pkg::data_t   dec_data;
    logic             dec_sbit;
    logic             dec_dbit;

    assign issue_wr = issue_valid && (issue_req.op == ecc_pkg::OP_WRITE);
    assign issue_rd = issue_valid && (issue_req.op == ecc_pkg::OP_READ);

    // Encoder sees the clean data.
    ecc_48_cal enc_u (
        .data_in    (issue_req.data),
        .parity_in  ('0),
        .bypass     (1'b0),
        .data_out   (),
        .parity_out (enc_parity),
        .mask       (),
        .sbit_err   (),
        .dbit_err   ()
    );

    ecc_48_cal dec_u (
        .data_in    (ram_rdata.data),
        .parity_in  (ram_rdata.parity),
        .bypass     (chk_bypass),
        .data_out   (dec_data),
        .parity_out (),
        .mask       (),
        .sbit_err   (dec_sbit),
        .dbit_err   (dec_dbit)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ram_we     <= 1'b0;
            rd_valid   <= 1'b0;
            chk_valid  <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            ram_we     <= issue_wr;
            rd_valid   <= issue_rd;
            chk_valid  <= rd_valid;
            resp_valid <= chk_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            ram_addr         <= issue_req.addr;
            ram_wdata.parity <= enc_parity;
            ram_wdata.data   <= issue_req.data ^ issue_req.inj_mask;
            rd_bypass        <= issue_req.bypass;
        end

        // Tag follows the RAM read latency.
        chk_addr   <= ram_addr;
        chk_bypass <= rd_bypass;

        if (chk_valid) begin
            resp.addr     <= chk_addr;
            resp.data     <= dec_data;
            resp.sbit_err <= dec_sbit;
            resp.dbit_err <= dec_dbit;
        end
    end

    // A write never fills the response slot a read would have used.
    a_no_write_resp: assert property (
        @(posedge clk) disable iff (!rst_n) ram_we |-> ##2 !resp_valid
    ) else $error("ecc_mem_ctrl: response for a write");

endmodule

// File: verilog/ecc_req_fifo.sv
module ecc_req_fifo (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    input  ecc_pkg::mem_req_t req,
    output logic              issue_valid,
    output ecc_pkg::mem_req_t issue_req,
    output logic              credit_return
);

    ecc_pkg::mem_req_t entries [ecc_pkg::REQ_DEPTH];
    ecc_pkg::req_ptr_t wr_ptr;
    ecc_pkg::req_ptr_t rd_ptr;
    ecc_pkg::req_cnt_t count;
    logic              pop;
    logic              full;

    assign pop  = (count != '0);  // Controller never stalls.
    assign full = (count == ecc_pkg::req_cnt_t'(ecc_pkg::REQ_DEPTH));

    assign issue_valid = pop;
    assign issue_req   = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (req_valid) begin
                wr_ptr <= wr_ptr + ecc_pkg::req_ptr_t'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + ecc_pkg::req_ptr_t'(1);
            end
            count <= count + ecc_pkg::req_cnt_t'(req_valid) - ecc_pkg::req_cnt_t'(pop);
            credit_return <= pop;  // One credit back per popped entry.
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            entries[wr_ptr] <= req;
        end
    end

    // Requester pushed without a credit.
    a_credit_violation: assert property (
        @(posedge clk) disable iff (!rst_n) !(req_valid && full)
    ) else $error("ecc_req_fifo: push while full");

endmodule

// File: verilog/ecc_word_ram.sv
module ecc_word_ram (
    input  logic               clk,
    input  logic               we,
    input  ecc_pkg::addr_t     addr,
    input  ecc_pkg::codeword_t wdata,
    output ecc_pkg::codeword_t rdata
);

    ecc_pkg::codeword_t mem [ecc_pkg::MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];  // Old data on a same-cycle write.
    end

endmodule

// File: verilog/ecc_48_cal.sv
module ecc_48_cal #(
    parameter int DATA_WIDTH   = ecc_pkg::DATA_W,
    parameter int PARITY_WIDTH = ecc_pkg::PAR_W
) (
    input  ecc_pkg::data_t   data_in,
    input  ecc_pkg::parity_t parity_in,
    input  logic             bypass,
    output ecc_pkg::data_t   data_out,
    output ecc_pkg::parity_t parity_out,
    output ecc_pkg::data_t   mask,
    output logic             sbit_err,
    output logic             dbit_err
);

    ecc_pkg::parity_t syndrome;
    logic             data_hit;
    logic             check_hit;
    logic             single_err;
    logic             multi_err;

    // Each check bit is the XOR of the data bits whose column has it set.
    function automatic ecc_pkg::parity_t calc_parity(input ecc_pkg::data_t d);
        ecc_pkg::parity_t p;
        p = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            for (int j = 0; j < PARITY_WIDTH; j++) begin
                if (ecc_pkg::ECC_COL[i][j]) begin
                    p[j] = p[j] ^ d[i];
                end
            end
        end
        return p;
    endfunction

    assign parity_out = calc_parity(data_in);
    assign syndrome   = parity_in ^ parity_out;

    always_comb begin
        mask = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            mask[i] = (syndrome == ecc_pkg::ECC_COL[i]);  // One-hot on a data hit.
        end

        data_hit   = |mask;
        check_hit  = $onehot(syndrome);  // Flipped check bit with intact data.
        single_err = data_hit || check_hit;
        // Even syndromes are double errors, as are odd ones outside the table.
        multi_err  = (syndrome != '0) && (!(^syndrome) || !single_err);

        sbit_err = !bypass && single_err;
        dbit_err = !bypass && multi_err;

        assert (!(sbit_err && dbit_err))
            else $error("ecc_48_cal: single and double error flagged together");
    end

    // Uncorrectable syndromes leave mask at zero, so data passes unchanged.
    assign data_out = bypass ? data_in : (data_in ^ mask);

endmodule

// File: verilog/ecc_pkg.sv
package ecc_pkg;

    localparam int DATA_W    = 48;
    localparam int PAR_W     = 7;
    localparam int ADDR_W    = 6;
    localparam int MEM_DEPTH = 1 << ADDR_W;
    localparam int REQ_DEPTH = 4;
    localparam int REQ_PTR_W = $clog2(REQ_DEPTH);
    localparam int REQ_CNT_W = $clog2(REQ_DEPTH + 1);
    localparam int CNT_W     = 16;

    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [PAR_W-1:0]     parity_t;
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [CNT_W-1:0]     cnt_t;
    typedef logic [REQ_PTR_W-1:0] req_ptr_t;
    typedef logic [REQ_CNT_W-1:0] req_cnt_t;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } req_op_e;

    typedef struct packed {
        req_op_e op;
        addr_t   addr;
        data_t   data;
        data_t   inj_mask;  // Data bits flipped after encoding.
        logic    bypass;    // Read returns raw stored data.
    } mem_req_t;

    typedef struct packed {
        addr_t addr;
        data_t data;
        logic  sbit_err;
        logic  dbit_err;
    } mem_resp_t;

    typedef struct packed {
        parity_t parity;
        data_t   data;
    } codeword_t;

    // Syndrome column of each data bit from bit 0 up.
    // All columns have odd weight, so two flips never alias a single one.
    localparam parity_t ECC_COL [DATA_W] = '{
        7'b1000011, 7'b1000101, 7'b1000110, 7'b0000111, 7'b1001001, 7'b1001010,
        7'b0001011, 7'b1001100, 7'b0001101, 7'b0001110, 7'b1001111, 7'b1010001,
        7'b1010010, 7'b0010011, 7'b1010100, 7'b0010101, 7'b0010110, 7'b1010111,
        7'b1011000, 7'b0011001, 7'b0011010, 7'b1011011, 7'b0011100, 7'b1011101,
        7'b1011110, 7'b0011111, 7'b1100001, 7'b1100010, 7'b0100011, 7'b1100100,
        7'b0100101, 7'b0100110, 7'b1100111, 7'b1101000, 7'b0101001, 7'b0101010,
        7'b1101011, 7'b0101100, 7'b1101101, 7'b1101110, 7'b0101111, 7'b1110000,
        7'b0110001, 7'b0110010, 7'b1110011, 7'b0110100, 7'b1110101, 7'b1110110
    };

endpackage
